// ==== hw/elevator_pkg.sv ====
`default_nettype none

package elevator_pkg;

	// building size
	localparam int num_floors = 8;
	localparam int floor_w = $clog2(num_floors);

	typedef logic [floor_w-1:0] floor_t; // landing number, 0 is the ground floor

	typedef logic [num_floors-1:0] call_vec_t; // one bit per landing

	// shaft motor command
	typedef enum logic [1:0] {
		engine_idle = 2'd0,
		engine_down = 2'd1,
		engine_up   = 2'd2
	} engine_e;

	// door drive command
	typedef enum logic [1:0] {
		door_hold  = 2'd0,
		door_open  = 2'd1,
		door_close = 2'd2
	} door_cmd_e;

	// door position as reported by the end switches
	typedef enum logic [1:0] {
		door_between = 2'd0,
		door_opened  = 2'd1,
		door_closed  = 2'd2
	} door_sense_e;

endpackage

`default_nettype wire

// ==== hw/call_register.sv ====
`timescale 1ns/1ps
`default_nettype none

module call_register (
	input  wire                     clock,
	input  wire                     reset,
	input  wire elevator_pkg::call_vec_t i_btn_cab,
	input  wire elevator_pkg::call_vec_t i_btn_hall_up,
	input  wire elevator_pkg::call_vec_t i_btn_hall_down,
	input  wire                     i_clear_en,
	input  wire elevator_pkg::floor_t    i_clear_floor,
	output elevator_pkg::call_vec_t      o_cab,
	output elevator_pkg::call_vec_t      o_hall_up,
	output elevator_pkg::call_vec_t      o_hall_down
);

	// no up button on the top landing, no down button on the ground floor
	localparam elevator_pkg::call_vec_t up_mask =
		~(elevator_pkg::call_vec_t'(1) << (elevator_pkg::num_floors - 1));
	localparam elevator_pkg::call_vec_t down_mask = ~elevator_pkg::call_vec_t'(1);

	elevator_pkg::call_vec_t clear_mask;

	always_comb begin
		clear_mask = '0;
		if (i_clear_en) begin
			clear_mask = elevator_pkg::call_vec_t'(1) << i_clear_floor; // served landing
		end
	end

	// set on press, clear on service, clear wins
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			o_cab       <= '0;
			o_hall_up   <= '0;
			o_hall_down <= '0;
		end else begin
			o_cab       <= (o_cab | i_btn_cab) & ~clear_mask;
			o_hall_up   <= (o_hall_up | i_btn_hall_up) & up_mask & ~clear_mask;
			o_hall_down <= (o_hall_down | i_btn_hall_down) & down_mask & ~clear_mask;
		end
	end

	// impossible hall calls must never be latched
	a_hall_edges : assert property (
		@(posedge clock) disable iff (!reset)
		!o_hall_up[elevator_pkg::num_floors-1] && !o_hall_down[0]
	) else $error("hall call latched at an end landing");

endmodule

`default_nettype wire

// ==== hw/dispatch_logic.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatch_logic (
	input  wire elevator_pkg::call_vec_t i_cab,
	input  wire elevator_pkg::call_vec_t i_hall_up,
	input  wire elevator_pkg::call_vec_t i_hall_down,
	input  wire elevator_pkg::floor_t    i_floor,
	output logic                         o_call_here,
	output logic                         o_call_above,
	output logic                         o_call_below
);

	elevator_pkg::call_vec_t merged; // any kind of call per landing

	assign merged = i_cab | i_hall_up | i_hall_down;

	// the car stops for any call, so direction of a hall call does not matter
	assign o_call_here = merged[i_floor];

	always_comb begin
		o_call_above = 1'b0;
		o_call_below = 1'b0;
		for (int i = 0; i < elevator_pkg::num_floors; i++) begin
			if (i > int'(i_floor)) begin
				o_call_above = o_call_above | merged[i];
			end
			if (i < int'(i_floor)) begin
				o_call_below = o_call_below | merged[i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/car_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module car_controller (
	input  wire                      clock,
	input  wire                      reset,
	input  wire                      i_call_here,
	input  wire                      i_call_above,
	input  wire                      i_call_below,
	input  wire                      i_floor_reached,
	input  wire                      i_door_ack,
	output elevator_pkg::engine_e    o_engine,
	output logic                     o_direction, // 1 is up
	output elevator_pkg::floor_t     o_floor,
	output logic                     o_clear_en,
	output logic                     o_door_req
);

	localparam elevator_pkg::floor_t top_floor =
		elevator_pkg::floor_t'(elevator_pkg::num_floors - 1);

	typedef enum logic [1:0] {
		st_rest,
		st_moving,
		st_serving
	} state_e;

	state_e state;
	logic   arrived;     // floor stepped on the last edge
	logic   calls_ahead;
	logic   calls_behind;
	logic   stop_now;

	assign calls_ahead  = o_direction ? i_call_above : i_call_below;
	assign calls_behind = o_direction ? i_call_below : i_call_above;
	assign stop_now     = arrived && (i_call_here || !calls_ahead);

	// motor cut right after the step edge when the new landing is a stop
	always_comb begin
		o_engine = elevator_pkg::engine_idle;
		if (state == st_moving && !stop_now) begin
			o_engine = o_direction ? elevator_pkg::engine_up : elevator_pkg::engine_down;
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			state       <= st_rest;
			o_direction <= 1'b1;
			o_floor     <= '0;
			arrived     <= 1'b0;
			o_clear_en  <= 1'b0;
			o_door_req  <= 1'b0;
		end else begin
			o_clear_en <= 1'b0;
			arrived    <= 1'b0;
			case (state)
				st_rest: begin
					if (i_call_here) begin
						state      <= st_serving;
						o_door_req <= 1'b1;
						o_clear_en <= 1'b1;
					end else if (calls_ahead) begin
						state <= st_moving;
					end else if (calls_behind) begin
						state       <= st_moving;
						o_direction <= !o_direction; // reverse
					end
				end
				st_moving: begin
					if (arrived && i_call_here) begin
						state      <= st_serving;
						o_door_req <= 1'b1;
						o_clear_en <= 1'b1;
					end else if (stop_now) begin
						state <= st_rest; // nothing left ahead
					end else if (i_floor_reached) begin
						if (o_direction && o_floor != top_floor) begin
							o_floor <= o_floor + 1'b1;
						end else if (!o_direction && o_floor != '0) begin
							o_floor <= o_floor - 1'b1;
						end
						arrived <= 1'b1;
					end
				end
				st_serving: begin
					if (o_door_req && i_door_ack) begin
						o_door_req <= 1'b0;
					end else if (!o_door_req && !i_door_ack) begin
						state <= st_rest; // handshake complete
					end
				end
				default: state <= st_rest;
			endcase
		end
	end

	a_engine_door : assert property (
		@(posedge clock) disable iff (!reset)
		(o_door_req || i_door_ack) |-> (o_engine == elevator_pkg::engine_idle)
	) else $error("engine running during door cycle");

	// motor never pushes the car past an end landing
	a_floor_range : assert property (
		@(posedge clock) disable iff (!reset)
		!((o_engine == elevator_pkg::engine_up) && (o_floor == top_floor)) &&
		!((o_engine == elevator_pkg::engine_down) && (o_floor == '0))
	) else $error("car driven past the end of the shaft");

endmodule

`default_nettype wire

// ==== hw/door_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module door_controller #(
	parameter int dwell_cycles = 8
) (
	input  wire                            clock,
	input  wire                            reset,
	input  wire                            i_door_req,
	input  wire elevator_pkg::door_sense_e i_door_sense,
	input  wire                            i_sensor_inside,
	input  wire                            i_overload,
	output elevator_pkg::door_cmd_e        o_door,
	output logic                           o_door_ack
);

	localparam int cnt_w = (dwell_cycles > 1) ? $clog2(dwell_cycles) : 1;
	localparam logic [cnt_w-1:0] dwell_last = cnt_w'(dwell_cycles - 1);

	typedef enum logic [2:0] {
		st_idle,
		st_opening,
		st_dwell,
		st_closing,
		st_done
	} state_e;

	state_e           state;
	logic [cnt_w-1:0] dwell_cnt;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			state     <= st_idle;
			dwell_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (i_door_req) begin
						state <= st_opening;
					end
				end
				st_opening: begin
					if (i_door_sense == elevator_pkg::door_opened) begin
						state     <= st_dwell;
						dwell_cnt <= '0; // dwell restarts after every reopen
					end
				end
				st_dwell: begin
					if (dwell_cnt == dwell_last) begin
						state <= st_closing;
					end else begin
						dwell_cnt <= dwell_cnt + 1'b1;
					end
				end
				st_closing: begin
					if (i_sensor_inside || i_overload) begin
						state <= st_opening; // obstruction, reopen
					end else if (i_door_sense == elevator_pkg::door_closed) begin
						state <= st_done;
					end
				end
				st_done: begin
					if (!i_door_req) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_comb begin
		o_door = elevator_pkg::door_hold;
		case (state)
			st_opening: o_door = elevator_pkg::door_open;
			st_closing: o_door = elevator_pkg::door_close;
			default:    o_door = elevator_pkg::door_hold;
		endcase
	end

	assign o_door_ack = (state == st_done);

	a_ack_closed : assert property (
		@(posedge clock) disable iff (!reset)
		o_door_ack |-> (i_door_sense == elevator_pkg::door_closed)
	) else $error("door ack while door not closed");

endmodule

`default_nettype wire

// ==== hw/elevator_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module elevator_top #(
	parameter int dwell_cycles = 8
) (
	input  wire                            clock,
	input  wire                            reset,
	input  wire elevator_pkg::call_vec_t   i_btn_cab,
	input  wire elevator_pkg::call_vec_t   i_btn_hall_up,
	input  wire elevator_pkg::call_vec_t   i_btn_hall_down,
	input  wire                            i_floor_reached,
	input  wire elevator_pkg::door_sense_e i_door_sense,
	input  wire                            i_sensor_inside,
	input  wire                            i_overload,
	output elevator_pkg::engine_e          o_engine,
	output elevator_pkg::door_cmd_e        o_door,
	output logic                           o_direction,
	output elevator_pkg::floor_t           o_level_display
);

	elevator_pkg::call_vec_t cab_calls;
	elevator_pkg::call_vec_t up_calls;
	elevator_pkg::call_vec_t down_calls;
	elevator_pkg::floor_t    car_floor;
	logic                    call_here;
	logic                    call_above;
	logic                    call_below;
	logic                    clear_en;
	logic                    door_req;
	logic                    door_ack;

	assign o_level_display = car_floor;

	call_register u_call_register (
		.clock           (clock),
		.reset           (reset),
		.i_btn_cab       (i_btn_cab),
		.i_btn_hall_up   (i_btn_hall_up),
		.i_btn_hall_down (i_btn_hall_down),
		.i_clear_en      (clear_en),
		.i_clear_floor   (car_floor),
		.o_cab           (cab_calls),
		.o_hall_up       (up_calls),
		.o_hall_down     (down_calls)
	);

	dispatch_logic u_dispatch_logic (
		.i_cab        (cab_calls),
		.i_hall_up    (up_calls),
		.i_hall_down  (down_calls),
		.i_floor      (car_floor),
		.o_call_here  (call_here),
		.o_call_above (call_above),
		.o_call_below (call_below)
	);

	car_controller u_car_controller (
		.clock           (clock),
		.reset           (reset),
		.i_call_here     (call_here),
		.i_call_above    (call_above),
		.i_call_below    (call_below),
		.i_floor_reached (i_floor_reached),
		.i_door_ack      (door_ack),
		.o_engine        (o_engine),
		.o_direction     (o_direction),
		.o_floor         (car_floor),
		.o_clear_en      (clear_en),
		.o_door_req      (door_req)
	);

	door_controller #(
		.dwell_cycles (dwell_cycles)
	) u_door_controller (
		.clock           (clock),
		.reset           (reset),
		.i_door_req      (door_req),
		.i_door_sense    (i_door_sense),
		.i_sensor_inside (i_sensor_inside),
		.i_overload      (i_overload),
		.o_door          (o_door),
		.o_door_ack      (door_ack)
	);

endmodule

`default_nettype wire

// ==== verification/elevator_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module elevator_checker (
	input  wire                            clock,
	input  wire                            reset,
	input  wire elevator_pkg::call_vec_t   i_btn_cab,
	input  wire elevator_pkg::call_vec_t   i_btn_hall_up,
	input  wire elevator_pkg::call_vec_t   i_btn_hall_down,
	input  wire elevator_pkg::engine_e     i_engine,
	input  wire elevator_pkg::door_cmd_e   i_door,
	input  wire                            i_direction,
	input  wire elevator_pkg::floor_t      i_level_display,
	output int                             o_errors,
	output int                             o_stops
);

	localparam elevator_pkg::call_vec_t up_ok =
		~(elevator_pkg::call_vec_t'(1) << (elevator_pkg::num_floors - 1));
	localparam elevator_pkg::call_vec_t down_ok = ~elevator_pkg::call_vec_t'(1);

	elevator_pkg::call_vec_t pending;   // shadow of latched calls
	elevator_pkg::call_vec_t served;
	elevator_pkg::floor_t    car_floor;
	logic                    car_up;
	elevator_pkg::door_cmd_e last_door;
	logic [4:0]              exp_stop;  // {found, up, floor}

	// nearest call in the travel direction, else nearest behind with the direction reversed
	function automatic logic [4:0] next_stop(
		input elevator_pkg::call_vec_t calls,
		input elevator_pkg::floor_t    floor,
		input logic                    up
	);
		int         f;
		logic       found;
		logic [4:0] result;
		found  = 1'b0;
		result = 5'd0;
		if (calls[floor]) begin
			result = {1'b1, up, floor}; // call at the landing, no motion
			found  = 1'b1;
		end
		f = int'(floor);
		while (!found && ((up && f < elevator_pkg::num_floors - 1) || (!up && f > 0))) begin
			f = up ? f + 1 : f - 1;
			if (calls[f]) begin
				result = {1'b1, up, elevator_pkg::floor_t'(f)};
				found  = 1'b1;
			end
		end
		f = int'(floor);
		while (!found && ((!up && f < elevator_pkg::num_floors - 1) || (up && f > 0))) begin
			f = up ? f - 1 : f + 1;
			if (calls[f]) begin
				result = {1'b1, !up, elevator_pkg::floor_t'(f)};
				found  = 1'b1;
			end
		end
		return result;
	endfunction

	always @(posedge clock or negedge reset) begin
		if (!reset) begin
			pending   <= '0;
			car_floor <= '0;
			car_up    <= 1'b1;
			last_door <= elevator_pkg::door_hold;
			o_stops   <= 0;
			o_errors  = 0;
		end else begin
			last_door <= i_door;
			served    = '0;
			if (i_door != elevator_pkg::door_hold && i_engine != elevator_pkg::engine_idle) begin
				$display("MISMATCH at time %0t: engine %0d running with door command %0d",
					$time, i_engine, i_door);
				o_errors = o_errors + 1;
			end
			// a fresh door cycle, reopen after obstruction comes from door_close
			if (i_door == elevator_pkg::door_open && last_door == elevator_pkg::door_hold) begin
				exp_stop = next_stop(pending, car_floor, car_up);
				o_stops <= o_stops + 1;
				if (!exp_stop[4]) begin
					$display("MISMATCH at time %0t: door opened at floor %0d with no call pending",
						$time, i_level_display);
					o_errors = o_errors + 1;
				end else begin
					if (i_level_display !== exp_stop[2:0] || i_direction !== exp_stop[3]) begin
						$display("MISMATCH at time %0t: stop at floor %0d dir %0d, expected %0d dir %0d",
							$time, i_level_display, i_direction, exp_stop[2:0], exp_stop[3]);
						o_errors = o_errors + 1;
					end
					car_floor <= exp_stop[2:0];
					car_up    <= exp_stop[3];
					served    = elevator_pkg::call_vec_t'(1) << exp_stop[2:0];
				end
			end
			pending <= (pending & ~served) | i_btn_cab | (i_btn_hall_up & up_ok) |
				(i_btn_hall_down & down_ok); // press after the clear survives
		end
	end

endmodule

`default_nettype wire

// ==== verification/elevator_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module elevator_tb;

	localparam int clk_period    = 4;
	localparam int dwell         = 6;
	localparam int step_cycles   = 5;  // cycles between landing pulses
	localparam int door_travel   = 3;  // cycles for a door to open or close
	localparam int quiet_cycles  = dwell + 8;
	localparam int random_rounds = 10;
	localparam int test_count    = 5 + random_rounds;
	localparam int worst_cycles  = 2 * step_cycles + 2 * door_travel + dwell + 20;
	localparam int timeout_ns    =
		test_count * elevator_pkg::num_floors * worst_cycles * clk_period;

	logic                       clock         = 1'b0;
	logic                       reset         = 1'b0;
	elevator_pkg::call_vec_t    btn_cab       = '0;
	elevator_pkg::call_vec_t    btn_hall_up   = '0;
	elevator_pkg::call_vec_t    btn_hall_down = '0;
	logic                       floor_reached = 1'b0;
	elevator_pkg::door_sense_e  door_sense    = elevator_pkg::door_closed;
	logic                       sensor_inside = 1'b0;
	logic                       overload      = 1'b0;
	elevator_pkg::engine_e      engine;
	elevator_pkg::door_cmd_e    door;
	logic                       direction;
	elevator_pkg::floor_t       level_display;
	int                         checker_errors;
	int                         stops;
	int                         tb_errors     = 0;
	int                         step_cnt      = 0;
	int                         door_cnt      = 0;
	integer                     seed          = 32'hfe7c_7039;

	always #(clk_period / 2) clock = ~clock;

	elevator_top #(
		.dwell_cycles (dwell)
	) DUT (
		.clock           (clock),
		.reset           (reset),
		.i_btn_cab       (btn_cab),
		.i_btn_hall_up   (btn_hall_up),
		.i_btn_hall_down (btn_hall_down),
		.i_floor_reached (floor_reached),
		.i_door_sense    (door_sense),
		.i_sensor_inside (sensor_inside),
		.i_overload      (overload),
		.o_engine        (engine),
		.o_door          (door),
		.o_direction     (direction),
		.o_level_display (level_display)
	);

	elevator_checker u_checker (
		.clock           (clock),
		.reset           (reset),
		.i_btn_cab       (btn_cab),
		.i_btn_hall_up   (btn_hall_up),
		.i_btn_hall_down (btn_hall_down),
		.i_engine        (engine),
		.i_door          (door),
		.i_direction     (direction),
		.i_level_display (level_display),
		.o_errors        (checker_errors),
		.o_stops         (stops)
	);

	// shaft model, a landing pulse every step_cycles while the motor runs
	always @(posedge clock) begin
		if (engine != elevator_pkg::engine_idle) begin
			if (step_cnt == step_cycles - 1) begin
				floor_reached <= 1'b1;
				step_cnt      <= 0;
			end else begin
				floor_reached <= 1'b0;
				step_cnt      <= step_cnt + 1;
			end
		end else begin
			floor_reached <= 1'b0;
			step_cnt      <= 0;
		end
	end

	// door model, passes through door_between on the way
	always @(posedge clock) begin
		if (door == elevator_pkg::door_open && door_sense != elevator_pkg::door_opened) begin
			if (door_cnt == door_travel - 1) begin
				door_sense <= elevator_pkg::door_opened;
				door_cnt   <= 0;
			end else begin
				door_sense <= elevator_pkg::door_between;
				door_cnt   <= door_cnt + 1;
			end
		end else if (door == elevator_pkg::door_close && door_sense != elevator_pkg::door_closed) begin
			if (door_cnt == door_travel - 1) begin
				door_sense <= elevator_pkg::door_closed;
				door_cnt   <= 0;
			end else begin
				door_sense <= elevator_pkg::door_between;
				door_cnt   <= door_cnt + 1;
			end
		end else begin
			door_cnt <= 0;
		end
	end

	// distinct landings that a call set will stop at
	function automatic int stop_count(
		input elevator_pkg::call_vec_t cab,
		input elevator_pkg::call_vec_t up,
		input elevator_pkg::call_vec_t down
	);
		elevator_pkg::call_vec_t merged;
		int                      n;
		merged = cab;
		n      = 0;
		for (int i = 0; i < elevator_pkg::num_floors; i++) begin
			if (up[i] && i != elevator_pkg::num_floors - 1) begin
				merged[i] = 1'b1;
			end
			if (down[i] && i != 0) begin
				merged[i] = 1'b1;
			end
			n = n + merged[i];
		end
		return n;
	endfunction

	task automatic press(
		input elevator_pkg::call_vec_t cab,
		input elevator_pkg::call_vec_t up,
		input elevator_pkg::call_vec_t down
	);
		@(posedge clock);
		btn_cab       <= cab;
		btn_hall_up   <= up;
		btn_hall_down <= down;
		@(posedge clock);
		btn_cab       <= '0;
		btn_hall_up   <= '0;
		btn_hall_down <= '0;
	endtask

	task automatic wait_stops(input int n);
		int target;
		target = stops + n;
		while (stops < target) begin
			@(posedge clock);
		end
	endtask

	task automatic expect_stop(input elevator_pkg::floor_t floor, input logic up);
		wait_stops(1);
		if (level_display !== floor || direction !== up) begin
			$display("MISMATCH at time %0t: stop at floor %0d dir %0d, expected floor %0d dir %0d",
				$time, level_display, direction, floor, up);
			tb_errors++;
		end
	endtask

	// car has settled once nothing happens for a while
	task automatic wait_idle();
		int quiet;
		quiet = 0;
		while (quiet < quiet_cycles) begin
			@(posedge clock);
			if (engine == elevator_pkg::engine_idle && door == elevator_pkg::door_hold) begin
				quiet++;
			end else begin
				quiet = 0;
			end
		end
	endtask

	task automatic check_rest(input int cycles);
		repeat (cycles) begin
			@(posedge clock);
			if (engine != elevator_pkg::engine_idle || door != elevator_pkg::door_hold) begin
				$display("MISMATCH at time %0t: engine %0d door %0d with no call pending",
					$time, engine, door);
				tb_errors++;
			end
		end
	endtask

	task automatic check_engine_idle();
		if (engine != elevator_pkg::engine_idle) begin
			$display("MISMATCH at time %0t: engine %0d running during a door cycle", $time, engine);
			tb_errors++;
		end
	endtask

	initial begin
		int                      target;
		int                      calls;
		elevator_pkg::floor_t    parked;
		elevator_pkg::call_vec_t cab;
		elevator_pkg::call_vec_t up;
		elevator_pkg::call_vec_t down;

		repeat (2) @(posedge clock);
		reset <= 1'b1;
		@(posedge clock);
		if (engine != elevator_pkg::engine_idle || door != elevator_pkg::door_hold ||
			direction !== 1'b1 || level_display !== 3'd0) begin
			$display("MISMATCH at time %0t: outputs after reset are not the rest values", $time);
			tb_errors++;
		end

		// single cabin call, then the cleared call needs a fresh press
		press(8'b0010_0000, '0, '0);
		expect_stop(3'd5, 1'b1);
		wait_idle();
		check_rest(20);
		press(8'b0010_0000, '0, '0);
		expect_stop(3'd5, 1'b1);
		wait_idle();

		// back to the ground floor, then the upward sweep
		press(8'b0000_0001, '0, '0);
		expect_stop(3'd0, 1'b0);
		wait_idle();
		press(8'b0100_0100, 8'b0000_1000, '0);
		expect_stop(3'd2, 1'b1);
		expect_stop(3'd3, 1'b1);
		expect_stop(3'd6, 1'b1);

		// reversal, calls below pressed with the door open at the top stop
		press(8'b0000_0010, '0, 8'b0001_0000);
		expect_stop(3'd4, 1'b0);
		expect_stop(3'd1, 1'b0);
		wait_idle();

		// obstruction while closing at floor 3, trip continues to 5
		press(8'b0010_1000, '0, '0);
		expect_stop(3'd3, 1'b1);
		while (door != elevator_pkg::door_close) begin
			@(posedge clock);
		end
		sensor_inside <= 1'b1;
		while (door != elevator_pkg::door_open) begin
			@(posedge clock);
			check_engine_idle();
		end
		sensor_inside <= 1'b0;
		while (door_sense != elevator_pkg::door_closed) begin
			@(posedge clock);
			check_engine_idle();
		end
		expect_stop(3'd5, 1'b1);
		wait_idle();

		// rest, then a call at the parked landing opens without motion
		check_rest(20);
		parked = level_display;
		press(elevator_pkg::call_vec_t'(1) << parked, '0, '0);
		target = stops + 1;
		while (stops < target) begin
			@(posedge clock);
			check_engine_idle();
		end
		if (level_display !== parked) begin
			$display("MISMATCH at time %0t: local call moved the car to floor %0d", $time,
				level_display);
			tb_errors++;
		end
		wait_idle();

		// seeded random call sets, pressed at rest
		for (int r = 0; r < random_rounds; r++) begin
			cab   = $random(seed);
			up    = $random(seed) & $random(seed);
			down  = $random(seed) & $random(seed);
			calls = stop_count(cab, up, down);
			press(cab, up, down);
			if (calls > 0) begin
				wait_stops(calls);
			end
			wait_idle();
		end

		$display("errors: checker %0d, testbench %0d, stops %0d", checker_errors, tb_errors,
			stops);
		if (checker_errors == 0 && tb_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#(timeout_ns);
		$display("watchdog: the car stopped making progress after %0d stops", stops);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/elevator_pkg.sv
hw/call_register.sv
hw/dispatch_logic.sv
hw/car_controller.sv
hw/door_controller.sv
hw/elevator_top.sv
verification/elevator_checker.sv
verification/elevator_tb.sv

// ==== Bender.yml ====
package:
  name: elevator

sources:
  - files:
      - hw/elevator_pkg.sv
      - hw/call_register.sv
      - hw/dispatch_logic.sv
      - hw/car_controller.sv
      - hw/door_controller.sv
      - hw/elevator_top.sv
  - target: test
    files:
      - verification/elevator_checker.sv
      - verification/elevator_tb.sv
